/* sources.f */
+incdir+hdl
hdl/hrm_pkg.sv
hdl/debouncer.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/byte_fifo.sv
hdl/mailroom_core.sv
hdl/outbox_drain.sv
hdl/hrm_top.sv
testbench/tb_hrm_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build with verilator, run, pass only when the pass line is printed
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module tb_hrm_top -o tb_hrm_top \
    && ./obj_dir/tb_hrm_top | tee /dev/stderr | grep -qF "All tests passed!" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* testbench/tb_hrm_top.sv */
`include "hrm_params.svh"

module tb_hrm_top;

    import hrm_pkg::*;

    localparam int CPB = `HRM_CLOCKS_PER_BAUD;
    localparam int DB_WAIT = `HRM_DEBOUNCE_CYCLES + 20;  // debounce plus sync slack
    localparam int NUM_ROWS = 22;
    localparam int BYTE_CYCLES = 10 * CPB;                // one 8N1 frame
    localparam int WATCHDOG_CYCLES = NUM_ROWS * 25 * BYTE_CYCLES;

    typedef struct packed {
        byte_t data;
        logic  rnd;    // use a random filler instead of data
        logic  hold;   // sw2 held while this byte goes in
        logic  press;  // sw1 press after the byte
        logic  drain;  // wait for every echo, then check leds
    } row_t;

    localparam row_t ROWS [NUM_ROWS] = '{
        '{8'h41, 1'b0, 1'b0, 1'b0, 1'b1},  // single byte echo
        '{8'h00, 1'b0, 1'b0, 1'b0, 1'b0},  // burst of 12 starts here
        '{8'hff, 1'b0, 1'b0, 1'b0, 1'b0},
        '{8'h55, 1'b0, 1'b0, 1'b0, 1'b0},
        '{8'haa, 1'b0, 1'b0, 1'b0, 1'b0},
        '{8'h00, 1'b1, 1'b0, 1'b0, 1'b0},
        '{8'h00, 1'b1, 1'b0, 1'b0, 1'b0},
        '{8'h00, 1'b1, 1'b0, 1'b0, 1'b0},
        '{8'h00, 1'b1, 1'b0, 1'b0, 1'b0},
        '{8'h00, 1'b1, 1'b0, 1'b0, 1'b0},
        '{8'h00, 1'b1, 1'b0, 1'b0, 1'b0},
        '{8'h00, 1'b1, 1'b0, 1'b0, 1'b0},
        '{8'h00, 1'b1, 1'b0, 1'b0, 1'b1},  // end of burst
        '{8'h10, 1'b0, 1'b1, 1'b0, 1'b0},  // paused, held in inbox
        '{8'h20, 1'b0, 1'b1, 1'b0, 1'b0},
        '{8'h30, 1'b0, 1'b1, 1'b0, 1'b0},
        '{8'h31, 1'b0, 1'b0, 1'b0, 1'b1},  // release, held bytes come first
        '{8'h77, 1'b0, 1'b1, 1'b0, 1'b0},
        '{8'h78, 1'b0, 1'b1, 1'b1, 1'b0},  // clear while paused drops both
        '{8'h5a, 1'b0, 1'b0, 1'b0, 1'b1},
        '{8'h3c, 1'b0, 1'b0, 1'b1, 1'b1},  // clear when idle, leds only
        '{8'hc3, 1'b0, 1'b0, 1'b0, 1'b1}
    };

    logic   clk = 1'b0;
    logic   reset, rx_line, tx_line, sw1, sw2;
    count_t leds;
    byte_t  got_q [$];    // decoded from tx
    byte_t  exp_q [$];    // due on tx, in order
    byte_t  held_q [$];   // sitting in the inbox while paused
    count_t moved;        // expected led value
    int     seed = 2;

    hrm_top dut0 (.clk(clk), .i_reset(reset), .i_rx(rx_line), .o_tx(tx_line),
                  .i_sw1(sw1), .i_sw2(sw2), .o_leds(leds));

    always #5 clk = ~clk;

    task automatic compare_value(input string name, input byte_t actual, input byte_t expected);
        if (actual !== expected)
        begin
            $display("MISMATCH %s: got 0x%02h expected 0x%02h", name, actual, expected);
            $display("Test failures found");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic send_byte(input byte_t b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};  // stop, data lsb first, start
        for (int i = 0; i < 10; i++)
        begin
            @(posedge clk);
            rx_line <= frame[i];
            repeat (CPB - 1) @(posedge clk);
        end
    endtask

    task automatic set_sw2(input logic level);
        @(posedge clk);
        sw2 <= level;
        repeat (DB_WAIT) @(posedge clk);  // level settles past debounce
    endtask

    task automatic press_sw1();
        @(posedge clk);
        sw1 <= 1'b1;
        repeat (DB_WAIT) @(posedge clk);
        sw1 <= 1'b0;
        repeat (DB_WAIT) @(posedge clk);
    endtask

    task automatic drain_echoes();
        byte_t want;
        while (exp_q.size() > 0)
        begin
            while (got_q.size() == 0)
                @(posedge clk);
            want = exp_q.pop_front();
            compare_value("o_tx byte", got_q.pop_front(), want);
        end
        compare_value("o_leds", leds, moved);
    endtask

    // tx decoder, samples each bit mid-window
    initial
    begin
        byte_t rx_byte;
        @(negedge reset);
        forever
        begin
            @(posedge clk);
            if (tx_line === 1'b0)
            begin
                repeat (CPB / 2) @(posedge clk);
                compare_value("o_tx start bit", 8'(tx_line), 8'h00);
                for (int k = 0; k < 8; k++)
                begin
                    repeat (CPB) @(posedge clk);
                    rx_byte[k] = tx_line;
                end
                repeat (CPB) @(posedge clk);
                compare_value("o_tx stop bit", 8'(tx_line), 8'h01);
                got_q.push_back(rx_byte);
            end
        end
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the echoes did not finish within the time allowed");
        $display("Test failures found");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        row_t  r;
        byte_t b;
        logic  sw2_held;
        reset    = 1'b1;
        rx_line  = 1'b1;  // uart idle
        sw1      = 1'b0;
        sw2      = 1'b0;
        moved    = '0;
        sw2_held = 1'b0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        repeat (2 * BYTE_CYCLES)  // quiet line before any traffic
        begin
            @(posedge clk);
            compare_value("o_tx idle", 8'(tx_line), 8'h01);
            compare_value("o_leds after reset", leds, 8'h00);
        end
        for (int n = 0; n < NUM_ROWS; n++)
        begin
            r = ROWS[n];
            if (!r.hold && sw2_held)
            begin
                compare_value("echoes while paused", 8'(got_q.size()), 8'h00);
                set_sw2(1'b0);
                sw2_held = 1'b0;
                moved = moved + count_t'(held_q.size());
                while (held_q.size() > 0)
                    exp_q.push_back(held_q.pop_front());
            end
            if (r.hold && !sw2_held)
            begin
                set_sw2(1'b1);
                sw2_held = 1'b1;
            end
            b = r.rnd ? byte_t'($random(seed)) : r.data;
            send_byte(b);
            if (r.hold)
                held_q.push_back(b);
            else
            begin
                exp_q.push_back(b);
                moved = moved + 1'b1;
            end
            if (r.drain)
                drain_echoes();
            if (r.press)
            begin
                press_sw1();
                held_q.delete();  // inbox cleared with the core
                moved = '0;
                compare_value("o_leds after clear", leds, 8'h00);
            end
        end
        repeat (3 * BYTE_CYCLES) @(posedge clk);
        compare_value("extra echoes", 8'(got_q.size()), 8'h00);
        $display("All tests passed!");
        $finish;
    end

endmodule

/* hdl/hrm_top.sv */
module hrm_top (
    input  logic            clk,
    input  logic            i_reset,
    input  logic            i_rx,     // uart in
    output logic            o_tx,     // uart out
    input  logic            i_sw1,    // press clears core and queues
    input  logic            i_sw2,    // hold to pause the core
    output hrm_pkg::count_t o_leds    // bytes moved
);

    import hrm_pkg::*;

    logic     sw1_press, sw2_level;
    logic     clear;                 // reset or sw1 press
    rx_word_t rx_word;
    byte_t    inbox_data, outbox_data, send_data;
    logic     inbox_empty, inbox_pop;
    logic     outbox_full, outbox_push;
    logic     tx_send, tx_busy;

    assign clear = i_reset | sw1_press;

    debouncer db_sw1 (.clk(clk), .i_reset(i_reset), .i_button(i_sw1),
                      .o_press(sw1_press), .o_release(), .o_level());
    debouncer db_sw2 (.clk(clk), .i_reset(i_reset), .i_button(i_sw2),
                      .o_press(), .o_release(), .o_level(sw2_level));

    uart_rx u_rx (.clk(clk), .i_reset(i_reset), .i_rx(i_rx), .o_word(rx_word));

    // inbox, full drops the byte
    byte_fifo u_inbox (.clk(clk), .i_reset(clear), .i_push(rx_word.strobe),
                       .i_data(rx_word.data), .i_pop(inbox_pop), .o_data(inbox_data),
                       .o_empty(inbox_empty), .o_full());

    mailroom_core u_core (.clk(clk), .i_reset(clear), .i_pause(sw2_level),
                          .i_inbox_data(inbox_data), .i_inbox_empty(inbox_empty),
                          .o_inbox_pop(inbox_pop), .i_outbox_full(outbox_full),
                          .o_outbox_push(outbox_push), .o_outbox_data(outbox_data),
                          .o_moved(o_leds));

    outbox_drain u_drain (.clk(clk), .i_reset(clear), .i_push(outbox_push),
                          .i_data(outbox_data), .o_full(outbox_full), .i_tx_busy(tx_busy),
                          .o_send(tx_send), .o_send_data(send_data));

    // transmitter finishes its frame across a clear
    uart_tx u_tx (.clk(clk), .i_reset(i_reset), .i_send(tx_send), .i_data(send_data),
                  .o_tx(o_tx), .o_busy(tx_busy));

endmodule

/* hdl/outbox_drain.sv */
module outbox_drain (
    input  logic           clk,
    input  logic           i_reset,      // also clears the queue
    input  logic           i_push,       // from the core
    input  hrm_pkg::byte_t i_data,
    output logic           o_full,
    input  logic           i_tx_busy,
    output logic           o_send,       // to uart_tx, also pops
    output hrm_pkg::byte_t o_send_data
);

    import hrm_pkg::*;

    logic send_q;
    logic q_empty;

    byte_fifo u_outbox (
        .clk     (clk),
        .i_reset (i_reset),
        .i_push  (i_push),
        .i_data  (i_data),
        .i_pop   (send_q),      // head leaves as it is sent
        .o_data  (o_send_data),
        .o_empty (q_empty),
        .o_full  (o_full)
    );

    // gap cycle after each pulse so tx busy is up before the next check
    always_ff @(posedge clk)
    begin
        if (i_reset)
            send_q <= 1'b0;
        else
            send_q <= !q_empty && !i_tx_busy && !send_q;
    end

    assign o_send = send_q;

endmodule

/* hdl/mailroom_core.sv */
module mailroom_core (
    input  logic            clk,
    input  logic            i_reset,
    input  logic            i_pause,        // debounced sw2 level
    input  hrm_pkg::byte_t  i_inbox_data,
    input  logic            i_inbox_empty,
    output logic            o_inbox_pop,
    input  logic            i_outbox_full,
    output logic            o_outbox_push,
    output hrm_pkg::byte_t  o_outbox_data,
    output hrm_pkg::count_t o_moved         // to the leds
);

    import hrm_pkg::*;

    core_state_t state;
    byte_t       hand_q;   // byte in hand between take and put
    count_t      moved_q;

    always_ff @(posedge clk)
    begin
        if (i_reset)
        begin
            state   <= CORE_IDLE;
            moved_q <= '0;
        end
        else
        begin
            unique case (state)
                // pause only checked here, a taken byte always gets delivered
                CORE_IDLE:
                    if (!i_inbox_empty && !i_outbox_full && !i_pause)
                        state <= CORE_TAKE;
                CORE_TAKE: state <= CORE_PUT;  // inbox pops this cycle
                CORE_PUT:
                begin
                    state   <= CORE_IDLE;
                    moved_q <= moved_q + 1'b1;  // mod 256
                end
                default: state <= CORE_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == CORE_TAKE)
            hand_q <= i_inbox_data;
    end

    assign o_inbox_pop   = (state == CORE_TAKE);
    assign o_outbox_push = (state == CORE_PUT);
    assign o_outbox_data = hand_q;
    assign o_moved       = moved_q;

    // only the core fills the outbox, so room seen in idle lasts to put
    a_push_has_room: assert property (@(posedge clk) disable iff (i_reset)
        o_outbox_push |-> !i_outbox_full);

endmodule

/* hdl/byte_fifo.sv */
`include "hrm_params.svh"

module byte_fifo (
    input  logic           clk,
    input  logic           i_reset,   // clears pointers and fill
    input  logic           i_push,
    input  hrm_pkg::byte_t i_data,
    input  logic           i_pop,
    output hrm_pkg::byte_t o_data,    // head of queue
    output logic           o_empty,
    output logic           o_full
);

    import hrm_pkg::*;

    localparam int DEPTH = 1 << `HRM_FIFO_DEPTH_LOG2;

    byte_t mem [DEPTH];
    ptr_t  wr_ptr, rd_ptr;
    fill_t fill_q;           // entries held
    logic  do_push, do_pop;

    assign do_push = i_push && !o_full;   // push when full is lost
    assign do_pop  = i_pop && !o_empty;   // pop when empty is ignored

    always_ff @(posedge clk)
    begin
        if (i_reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill_q <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (do_push && !do_pop)
                fill_q <= fill_q + 1'b1;
            else if (do_pop && !do_push)
                fill_q <= fill_q - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (do_push)
            mem[wr_ptr] <= i_data;
    end

    assign o_data  = mem[rd_ptr];
    assign o_empty = (fill_q == '0);
    assign o_full  = (fill_q == fill_t'(DEPTH));

    a_fill_bound: assert property (@(posedge clk) disable iff (i_reset)
        fill_q <= fill_t'(DEPTH));

endmodule

/* hdl/uart_tx.sv */
`include "hrm_params.svh"

module uart_tx (
    input  logic           clk,
    input  logic           i_reset,
    input  logic           i_send,   // one-cycle start request
    input  hrm_pkg::byte_t i_data,
    output logic           o_tx,     // serial line
    output logic           o_busy
);

    import hrm_pkg::*;

    localparam int CPB = `HRM_CLOCKS_PER_BAUD;
    localparam int BW = $clog2(CPB);
    localparam logic [BW-1:0] BAUD_LAST = BW'(CPB - 1);

    uart_state_t   state;
    logic [BW-1:0] baud_cnt;
    logic [2:0]    bit_idx;
    byte_t         shift_q;  // remaining data bits

    always_ff @(posedge clk)
    begin
        if (i_reset)
        begin
            state    <= UART_IDLE;
            o_tx     <= 1'b1;  // line idles high
            baud_cnt <= '0;
            bit_idx  <= '0;
        end
        else
        begin
            baud_cnt <= baud_cnt + 1'b1;
            unique case (state)
                UART_IDLE:
                begin
                    baud_cnt <= '0;
                    if (i_send)
                    begin
                        state <= UART_START;
                        o_tx  <= 1'b0;  // start bit
                    end
                end
                UART_START:
                begin
                    if (baud_cnt == BAUD_LAST)
                    begin
                        baud_cnt <= '0;
                        bit_idx  <= '0;
                        state    <= UART_DATA;
                        o_tx     <= shift_q[0];
                    end
                end
                UART_DATA:
                begin
                    if (baud_cnt == BAUD_LAST)
                    begin
                        baud_cnt <= '0;
                        bit_idx  <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7)
                        begin
                            state <= UART_STOP;
                            o_tx  <= 1'b1;  // stop bit
                        end
                        else
                            o_tx <= shift_q[0];
                    end
                end
                UART_STOP:
                begin
                    if (baud_cnt == BAUD_LAST)
                        state <= UART_IDLE;  // busy drops here
                end
                default: state <= UART_IDLE;
            endcase
        end
    end

    // shifter, loaded on send and stepped as each data bit goes out
    always_ff @(posedge clk)
    begin
        if (state == UART_IDLE && i_send)
            shift_q <= i_data;
        else if (state != UART_IDLE && state != UART_STOP && baud_cnt == BAUD_LAST)
            shift_q <= {1'b0, shift_q[7:1]};
    end

    assign o_busy = (state != UART_IDLE);

    // the drain's gap cycle must keep requests away from a busy frame
    a_no_send_busy: assert property (@(posedge clk) disable iff (i_reset)
        i_send |-> !o_busy);

endmodule

/* hdl/uart_rx.sv */
`include "hrm_params.svh"

module uart_rx (
    input  logic              clk,
    input  logic              i_reset,
    input  logic              i_rx,     // serial line, idles high
    output hrm_pkg::rx_word_t o_word    // strobe + byte
);

    import hrm_pkg::*;

    localparam int CPB = `HRM_CLOCKS_PER_BAUD;
    localparam int BW = $clog2(CPB);
    localparam logic [BW-1:0] BAUD_LAST = BW'(CPB - 1);
    localparam logic [BW-1:0] HALF_LAST = BW'(CPB / 2 - 1);

    uart_state_t   state;
    logic          rx_meta, rx_s;   // synchronized line
    logic [BW-1:0] baud_cnt;
    logic [2:0]    bit_idx;
    byte_t         shift_q;          // data bits, filled from the top
    logic          strobe_q;
    byte_t         data_q;

    always_ff @(posedge clk)
    begin
        if (i_reset)
        begin
            state    <= UART_IDLE;
            rx_meta  <= 1'b1;
            rx_s     <= 1'b1;
            baud_cnt <= '0;
            bit_idx  <= '0;
            strobe_q <= 1'b0;
        end
        else
        begin
            rx_meta  <= i_rx;
            rx_s     <= rx_meta;
            strobe_q <= 1'b0;
            baud_cnt <= baud_cnt + 1'b1;
            unique case (state)
                UART_IDLE:
                begin
                    baud_cnt <= '0;
                    if (!rx_s)
                        state <= UART_START;  // falling edge seen
                end
                UART_START:
                begin
                    if (baud_cnt == HALF_LAST)
                    begin
                        baud_cnt <= '0;
                        bit_idx  <= '0;
                        // still low at mid-bit, else it was a glitch
                        state    <= rx_s ? UART_IDLE : UART_DATA;
                    end
                end
                UART_DATA:
                begin
                    if (baud_cnt == BAUD_LAST)
                    begin
                        baud_cnt <= '0;
                        bit_idx  <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7)
                            state <= UART_STOP;
                    end
                end
                UART_STOP:
                begin
                    if (baud_cnt == BAUD_LAST)
                    begin
                        state    <= UART_IDLE;
                        strobe_q <= rx_s;  // bad stop bit drops the byte
                    end
                end
                default: state <= UART_IDLE;
            endcase
        end
    end

    // payload path, no reset
    always_ff @(posedge clk)
    begin
        if (state == UART_DATA && baud_cnt == BAUD_LAST)
            shift_q <= {rx_s, shift_q[7:1]};  // lsb first
        if (state == UART_STOP && baud_cnt == BAUD_LAST)
            data_q <= shift_q;
    end

    assign o_word = '{strobe: strobe_q, data: data_q};

    // a frame takes ten bit times, so strobes can never touch
    a_single_strobe: assert property (@(posedge clk) disable iff (i_reset)
        o_word.strobe |=> !o_word.strobe);

endmodule

/* hdl/debouncer.sv */
`include "hrm_params.svh"

module debouncer (
    input  logic clk,
    input  logic i_reset,
    input  logic i_button,   // raw, asynchronous, high when pressed
    output logic o_press,    // one cycle on accepted press
    output logic o_release,  // one cycle on accepted release
    output logic o_level     // debounced state
);

    localparam int DB_CYCLES = `HRM_DEBOUNCE_CYCLES;
    localparam int DW = $clog2(DB_CYCLES);
    localparam logic [DW-1:0] DB_LAST = DW'(DB_CYCLES - 1);

    logic          sync_a, sync_b;  // two-flop synchronizer
    logic [DW-1:0] stable_cnt;
    logic          level_q;

    always_ff @(posedge clk)
    begin
        if (i_reset)
        begin
            sync_a     <= 1'b0;
            sync_b     <= 1'b0;
            stable_cnt <= '0;
            level_q    <= 1'b0;
            o_press    <= 1'b0;
            o_release  <= 1'b0;
        end
        else
        begin
            sync_a    <= i_button;
            sync_b    <= sync_a;
            o_press   <= 1'b0;  // pulses by default low
            o_release <= 1'b0;
            if (sync_b == level_q)
                stable_cnt <= '0;  // bounce or no change, start over
            else if (stable_cnt == DB_LAST)
            begin
                // input held long enough, accept it
                stable_cnt <= '0;
                level_q    <= sync_b;
                o_press    <= sync_b;
                o_release  <= ~sync_b;
            end
            else
                stable_cnt <= stable_cnt + 1'b1;
        end
    end

    assign o_level = level_q;

endmodule

/* hdl/hrm_pkg.sv */
`include "hrm_params.svh"

package hrm_pkg;

    typedef logic [7:0] byte_t;   // one data byte
    typedef logic [7:0] count_t;  // moved-byte counter, wraps at 256

    // queue addressing, fill needs one extra bit for the full case
    typedef logic [`HRM_FIFO_DEPTH_LOG2-1:0] ptr_t;
    typedef logic [`HRM_FIFO_DEPTH_LOG2:0]   fill_t;

    // receiver output, strobe high for one cycle with a good byte
    typedef struct packed {
        logic  strobe;
        byte_t data;
    } rx_word_t;

    // copy loop states
    typedef enum logic [1:0] {CORE_IDLE, CORE_TAKE, CORE_PUT} core_state_t;

    // serial frame position, same for rx and tx
    typedef enum logic [1:0] {UART_IDLE, UART_START, UART_DATA, UART_STOP} uart_state_t;

endpackage

/* hdl/hrm_params.svh */
`ifndef HRM_PARAMS_SVH
`define HRM_PARAMS_SVH

// uart bit period in clock cycles
`define HRM_CLOCKS_PER_BAUD 104

// stable cycles needed before a button change counts
`define HRM_DEBOUNCE_CYCLES 1000

// queue depth as a power of two, 4 -> 16 entries
`define HRM_FIFO_DEPTH_LOG2 4

`endif
